// File: hw/rope_pkg.sv
package rope_pkg;

  // ******************************
  // Rope geometry and playfield
  // ******************************

  localparam int N_NODES     = 8;
  localparam int PIX_W       = 12;   // Raw pointer pixels, unsigned
  localparam int FIELD_X_MAX = 639;
  localparam int FIELD_Y_MAX = 479;
  localparam int SEG_LEN     = 16;   // Rest spacing in pixels

  // ******************************
  // Fixed point and queueing
  // ******************************

  localparam int FRAC       = 4;     // Fractional bits of a position
  localparam int COORD_W    = 16;
  localparam int SUM_W      = COORD_W + 2;  // Headroom for prev + 2 cur + next
  localparam int FIFO_DEPTH = 4;
  localparam int DROP_W     = 8;

  typedef logic signed [COORD_W-1:0] coord_t;

  typedef struct packed {
    coord_t x;
    coord_t y;
  } point_t;

  typedef point_t [N_NODES-1:0] frame_t;  // Node 0 is the head

  // Rest position of node idx, x at idx * SEG_LEN pixels and y at zero
  function automatic point_t rest_point(int idx);
    point_t p;
    p.x = coord_t'(idx * SEG_LEN) <<< FRAC;
    p.y = '0;
    return p;
  endfunction

endpackage

// File: hw/pointer_sampler.sv
`timescale 1ns/1ps

module pointer_sampler (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       ptr_valid,
  input  logic [rope_pkg::PIX_W-1:0] ptr_x,
  input  logic [rope_pkg::PIX_W-1:0] ptr_y,
  output logic                       push,
  output rope_pkg::point_t           push_data
);

  import rope_pkg::*;

  point_t scaled;       // Clamped point in fixed point
  point_t last_target;  // Last point handed to the queue
  logic   fresh;

  // Clamp to the playfield and move into fixed point
  function automatic coord_t to_fixed(logic [PIX_W-1:0] raw, int max_pix);
    logic [PIX_W-1:0] lim;
    coord_t           fixed;
    lim   = (raw > max_pix) ? PIX_W'(max_pix) : raw;
    fixed = coord_t'(lim);
    return fixed <<< FRAC;
  endfunction

  always_comb begin
    scaled.x = to_fixed(ptr_x, FIELD_X_MAX);
    scaled.y = to_fixed(ptr_y, FIELD_Y_MAX);
  end

  assign fresh = (scaled != last_target);

  always_ff @(posedge clk) begin
    if (!reset) begin
      push        <= 1'b0;
      last_target <= rest_point(0);  // Head rest position
    end else begin
      push <= ptr_valid && fresh;
      if (ptr_valid && fresh) begin
        last_target <= scaled;
      end
    end
  end

  // Holds the new target in the cycle push is high
  assign push_data = last_target;

endmodule

// File: hw/event_fifo.sv
`timescale 1ns/1ps

module event_fifo #(
  parameter type payload_t = rope_pkg::point_t,
  parameter int  DEPTH     = rope_pkg::FIFO_DEPTH
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        push,
  input  payload_t                    push_data,
  input  logic                        pop,
  output payload_t                    head_data,
  output logic                        empty,
  output logic [rope_pkg::DROP_W-1:0] drop_count
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t           mem [DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;
  logic               full;
  logic               wr_en;
  logic               rd_en;

  // Wrap at DEPTH so any depth works
  function automatic logic [PTR_W-1:0] bump(logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign empty     = (count == '0);
  assign full      = (count == CNT_W'(DEPTH));
  assign wr_en     = push && !full;
  assign rd_en     = pop && !empty;
  assign head_data = mem[rd_ptr];  // First word fall through

  always_ff @(posedge clk) begin
    if (!reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      drop_count <= '0;
    end else begin
      if (wr_en) wr_ptr <= bump(wr_ptr);
      if (rd_en) rd_ptr <= bump(rd_ptr);
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      if (push && full && !(&drop_count)) begin
        drop_count <= drop_count + 1'b1;  // Saturating loss counter
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= push_data;
    end
  end

endmodule

// File: hw/rope_relax.sv
`timescale 1ns/1ps

module rope_relax (
  input  rope_pkg::point_t prev,
  input  rope_pkg::point_t cur,
  input  rope_pkg::point_t next,
  input  logic             is_tail,
  output rope_pkg::point_t relaxed
);

  import rope_pkg::*;

  // Weighted average of one axis, floor division through arithmetic shift
  function automatic coord_t smooth(coord_t p, coord_t c, coord_t n, logic tail);
    logic signed [SUM_W-1:0] sum;
    logic signed [SUM_W-1:0] avg;
    if (tail) begin
      sum = (SUM_W'(p) + SUM_W'(c)) <<< 1;  // Twice (p + c), same shift below
    end else begin
      sum = SUM_W'(p) + (SUM_W'(c) <<< 1) + SUM_W'(n);
    end
    avg = sum >>> 2;
    return avg[COORD_W-1:0];
  endfunction

  always_comb begin
    relaxed.x = smooth(prev.x, cur.x, next.x, is_tail);
    relaxed.y = smooth(prev.y, cur.y, next.y, is_tail);
  end

endmodule

// File: hw/rope_core.sv
`timescale 1ns/1ps

module rope_core (
  input  logic              clk,
  input  logic              reset,
  input  logic              empty,
  input  rope_pkg::point_t  head_data,
  output logic              pop,
  output logic              frame_valid,
  output rope_pkg::frame_t  frame
);

  import rope_pkg::*;

  frame_t             nodes;       // Current node positions
  frame_t             nodes_next;  // Positions after this cycle's slot
  point_t             relaxed [1:N_NODES-1];
  point_t             target;      // Head target of the running sweep
  logic [N_NODES-1:0] token;       // One hot slot select
  logic [N_NODES-1:0] token_rot;
  logic               idle;

  // ******************************
  // Relaxation per node
  // ******************************

  for (genvar i = 1; i < N_NODES; i++) begin : g_relax
    rope_relax relax_i (
      .prev    (nodes[i-1]),
      .cur     (nodes[i]),
      .next    (nodes[(i == N_NODES-1) ? i : i+1]),  // Tail has no next node
      .is_tail (i == N_NODES-1),
      .relaxed (relaxed[i])
    );
  end

  // ******************************
  // Sweep control
  // ******************************

  assign idle      = !(|token) && !frame_valid;  // Free again after the frame strobe
  assign pop       = idle && !empty;
  assign token_rot = {token[N_NODES-2:0], token[N_NODES-1]};

  // Only the selected slot moves, earlier slots already hold new values
  always_comb begin
    nodes_next = nodes;
    if (token[0]) begin
      nodes_next[0] = target;
    end
    for (int k = 1; k < N_NODES; k++) begin
      if (token[k]) begin
        nodes_next[k] = relaxed[k];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      token       <= '0;
      frame_valid <= 1'b0;
      for (int k = 0; k < N_NODES; k++) begin
        nodes[k] <= rest_point(k);  // Straight rope along x
      end
    end else begin
      nodes       <= nodes_next;
      frame_valid <= token[N_NODES-1];  // Last slot done
      if (pop) begin
        token <= N_NODES'(1);
      end else if (token[N_NODES-1]) begin
        token <= '0;  // Sweep ends
      end else begin
        token <= token_rot;
      end
    end
  end

  // ******************************
  // Payload registers
  // ******************************

  always_ff @(posedge clk) begin
    if (pop) begin
      target <= head_data;
    end
    if (token[N_NODES-1]) begin
      frame <= nodes_next;  // Includes the tail written this cycle
    end
  end

endmodule

// File: hw/rope_top.sv
`timescale 1ns/1ps

module rope_top (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        ptr_valid,
  input  logic [rope_pkg::PIX_W-1:0]  ptr_x,
  input  logic [rope_pkg::PIX_W-1:0]  ptr_y,
  output logic                        frame_valid,
  output rope_pkg::frame_t            frame,
  output logic [rope_pkg::DROP_W-1:0] drop_count
);

  import rope_pkg::*;

  logic   push;
  point_t push_data;
  logic   pop;
  point_t head_data;
  logic   empty;

  pointer_sampler sampler_i (
    .clk       (clk),
    .reset     (reset),
    .ptr_valid (ptr_valid),
    .ptr_x     (ptr_x),
    .ptr_y     (ptr_y),
    .push      (push),
    .push_data (push_data)
  );

  event_fifo #(
    .payload_t (point_t),
    .DEPTH     (FIFO_DEPTH)
  ) fifo_i (
    .clk        (clk),
    .reset      (reset),
    .push       (push),
    .push_data  (push_data),
    .pop        (pop),
    .head_data  (head_data),
    .empty      (empty),
    .drop_count (drop_count)
  );

  rope_core core_i (
    .clk         (clk),
    .reset       (reset),
    .empty       (empty),
    .head_data   (head_data),
    .pop         (pop),
    .frame_valid (frame_valid),
    .frame       (frame)
  );

endmodule

// File: test/tb_rope_model.svh
`ifndef TB_ROPE_MODEL_SVH
`define TB_ROPE_MODEL_SVH

// ******************************
// Reference model of the rope
// ******************************

logic [31:0] lfsr_state = 32'h71c3_eb1b;
point_t      model_last;              // Last target that reached the queue
point_t      model_nodes [N_NODES];
frame_t      exp_frames [$];          // Frames still owed by the DUT

// Galois LFSR, taps 32 30 26 25
function automatic logic [31:0] lfsr_next(logic [31:0] s);
  logic lsb;
  lsb = s[0];
  s = s >> 1;
  if (lsb) begin
    s = s ^ 32'hA300_0000;
  end
  return s;
endfunction

function automatic int rand_bits(int n);
  int v;
  v = 0;
  for (int i = 0; i < n; i++) begin
    lfsr_state = lfsr_next(lfsr_state);  // One step per bit taken
    v = (v << 1) | int'(lfsr_state[0]);
  end
  return v;
endfunction

function automatic int random_pixel(int max_pix, int nbits);
  return rand_bits(nbits) % (max_pix + 1);
endfunction

// Pixel strictly above the field limit but still inside PIX_W bits
function automatic int random_over(int max_pix);
  return max_pix + 1 + rand_bits(PIX_W) % ((1 << PIX_W) - max_pix - 1);
endfunction

function automatic coord_t clamp_scale(int raw, int max_pix);
  int lim;
  lim = (raw > max_pix) ? max_pix : raw;
  return coord_t'(lim * (2 ** FRAC));
endfunction

function automatic point_t sample_point(int raw_x, int raw_y);
  point_t p;
  p.x = clamp_scale(raw_x, FIELD_X_MAX);
  p.y = clamp_scale(raw_y, FIELD_Y_MAX);
  return p;
endfunction

// Floor of the weighted average, tail only sees its predecessor
function automatic coord_t relax_axis(coord_t p, coord_t c, coord_t n, bit tail);
  int sum;
  if (tail) begin
    return coord_t'((int'(p) + int'(c)) >>> 1);
  end
  sum = int'(p) + 2 * int'(c) + int'(n);
  return coord_t'(sum >>> 2);
endfunction

function automatic void model_reset();
  model_last = '0;
  for (int i = 0; i < N_NODES; i++) begin
    model_nodes[i].x = coord_t'(i * SEG_LEN * (2 ** FRAC));
    model_nodes[i].y = '0;
  end
  exp_frames.delete();
endfunction

// Sampler rule and one sequential sweep, returns 1 when a frame is owed
function automatic bit model_event(int raw_x, int raw_y);
  point_t t;
  point_t nxt;
  frame_t f;
  bit     tail;
  t = sample_point(raw_x, raw_y);
  if (t == model_last) begin
    return 1'b0;  // Repeat target, no push
  end
  model_last = t;
  model_nodes[0] = t;
  for (int k = 1; k < N_NODES; k++) begin
    tail = (k == N_NODES - 1);
    nxt  = tail ? model_nodes[k] : model_nodes[k+1];
    model_nodes[k].x = relax_axis(model_nodes[k-1].x, model_nodes[k].x, nxt.x, tail);
    model_nodes[k].y = relax_axis(model_nodes[k-1].y, model_nodes[k].y, nxt.y, tail);
  end
  for (int k = 0; k < N_NODES; k++) begin
    f[k] = model_nodes[k];
  end
  exp_frames.push_back(f);
  return 1'b1;
endfunction

`endif

// File: test/tb_rope.sv
`timescale 1ns/1ps

module tb_rope;

  import rope_pkg::*;

  localparam int RAND_EVENTS  = 20;
  localparam int CLAMP_EVENTS = 6;
  localparam int BURST_EVENTS = FIFO_DEPTH + 4;
  localparam int TOTAL_EVENTS = 1 + RAND_EVENTS + CLAMP_EVENTS + 3 + BURST_EVENTS;
  localparam int SLOT_CYCLES  = N_NODES + 4;  // One event through an idle pipeline
  localparam int MAX_CYCLES   = TOTAL_EVENTS * SLOT_CYCLES + 300;
  localparam int DRAIN_LIMIT  = SLOT_CYCLES * (FIFO_DEPTH + 2);

  logic              clk;
  logic              reset;
  logic              ptr_valid;
  logic [PIX_W-1:0]  ptr_x;
  logic [PIX_W-1:0]  ptr_y;
  logic              frame_valid;
  frame_t            frame;
  logic [DROP_W-1:0] drop_count;

  int cycle_count;
  int errors;
  int frames_seen;
  int tests_passed;
  int tests_failed;
  bit check_frames;

  `include "tb_rope_model.svh"

  rope_top dut_i (
    .clk         (clk),
    .reset       (reset),
    .ptr_valid   (ptr_valid),
    .ptr_x       (ptr_x),
    .ptr_y       (ptr_y),
    .frame_valid (frame_valid),
    .frame       (frame),
    .drop_count  (drop_count)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  // ******************************
  // Frame monitor
  // ******************************

  always @(posedge clk) begin : monitor
    frame_t exp;
    if (reset && frame_valid) begin
      frames_seen++;
      if (check_frames) begin
        assert (exp_frames.size() != 0) else begin
          $display("Unexpected frame at %0t ns with no pending event to match", $time);
          errors++;
        end
        if (exp_frames.size() != 0) begin
          exp = exp_frames.pop_front();
          for (int k = 0; k < N_NODES; k++) begin
            assert (frame[k] == exp[k]) else begin
              $display("[FAIL] %0t ns: node %0d is (%0d,%0d), expected (%0d,%0d)",
                       $time, k, frame[k].x, frame[k].y, exp[k].x, exp[k].y);
              errors++;
            end
          end
        end
      end
    end
  end

  // ******************************
  // Stimulus tasks
  // ******************************

  task automatic apply_reset();
    @(posedge clk);
    reset     <= 1'b0;
    ptr_valid <= 1'b0;
    repeat (10) @(posedge clk);
    reset <= 1'b1;
    model_reset();
  endtask

  task automatic drive_event(int raw_x, int raw_y);
    @(posedge clk);
    ptr_valid <= 1'b1;
    ptr_x     <= PIX_W'(raw_x);
    ptr_y     <= PIX_W'(raw_y);
    void'(model_event(raw_x, raw_y));
  endtask

  task automatic idle_cycles(int n);
    @(posedge clk);
    ptr_valid <= 1'b0;
    repeat (n - 1) @(posedge clk);
  endtask

  // Random in-range point that the sampler will not suppress
  task automatic pick_fresh(output int raw_x, output int raw_y);
    raw_x = random_pixel(FIELD_X_MAX, 10);
    raw_y = random_pixel(FIELD_Y_MAX, 9);
    while (sample_point(raw_x, raw_y) == model_last) begin
      raw_x = random_pixel(FIELD_X_MAX, 10);
      raw_y = random_pixel(FIELD_Y_MAX, 9);
    end
  endtask

  task automatic report_test(string name, int err_before);
    if (errors == err_before) begin
      $display("%-24s pass", name);
      tests_passed++;
    end else begin
      $display("%-24s fail, %0d errors", name, errors - err_before);
      tests_failed++;
    end
  endtask

  task automatic finish_test(string name);
    int n;
    n = 0;
    while (exp_frames.size() != 0 && n < DRAIN_LIMIT) begin
      @(posedge clk);
      n++;
    end
    idle_cycles(SLOT_CYCLES);  // Room for a late extra frame
    @(negedge clk);
    assert (exp_frames.size() == 0) else begin
      $display("Test %s ended with %0d expected frames never produced",
               name, exp_frames.size());
      errors++;
      exp_frames.delete();
    end
  endtask

  // ******************************
  // Test sequence
  // ******************************

  initial begin
    int err_before;
    int raw_x;
    int raw_y;
    int base_frames;
    int n;
    clk          = 1'b0;
    reset        = 1'b0;
    ptr_valid    = 1'b0;
    ptr_x        = '0;
    ptr_y        = '0;
    check_frames = 1'b1;
    apply_reset();

    err_before = errors;
    raw_x = 1 + random_pixel(FIELD_X_MAX - 1, 10);  // Never the rest head
    raw_y = random_pixel(FIELD_Y_MAX, 9);
    drive_event(raw_x, raw_y);
    idle_cycles(SLOT_CYCLES - 1);
    finish_test("reset single event");
    report_test("reset single event", err_before);

    err_before = errors;
    for (int i = 0; i < RAND_EVENTS; i++) begin
      drive_event(random_pixel(FIELD_X_MAX, 10), random_pixel(FIELD_Y_MAX, 9));
      idle_cycles(SLOT_CYCLES - 1);
    end
    finish_test("random spaced events");
    report_test("random spaced events", err_before);

    err_before = errors;
    for (int i = 0; i < CLAMP_EVENTS; i++) begin
      raw_x = (i % 3 == 1) ? random_pixel(FIELD_X_MAX, 10) : random_over(FIELD_X_MAX);
      raw_y = (i % 3 == 0) ? random_pixel(FIELD_Y_MAX, 9) : random_over(FIELD_Y_MAX);
      drive_event(raw_x, raw_y);
      idle_cycles(SLOT_CYCLES - 1);
    end
    finish_test("clamped events");
    report_test("clamped events", err_before);

    err_before  = errors;
    base_frames = frames_seen;
    pick_fresh(raw_x, raw_y);
    drive_event(raw_x, raw_y);
    idle_cycles(SLOT_CYCLES - 1);
    drive_event(raw_x, raw_y);  // Same target again
    idle_cycles(SLOT_CYCLES - 1);
    pick_fresh(raw_x, raw_y);
    drive_event(raw_x, raw_y);
    idle_cycles(SLOT_CYCLES - 1);
    finish_test("repeat suppression");
    assert (frames_seen - base_frames == 2) else begin
      $display("Repeat test produced %0d frames instead of 2", frames_seen - base_frames);
      errors++;
    end
    report_test("repeat suppression", err_before);

    apply_reset();
    err_before   = errors;
    check_frames = 1'b0;
    base_frames  = frames_seen;
    for (int i = 0; i < BURST_EVENTS; i++) begin
      pick_fresh(raw_x, raw_y);
      drive_event(raw_x, raw_y);
    end
    idle_cycles(1);
    n = 0;
    while ((frames_seen - base_frames) + int'(drop_count) != BURST_EVENTS
           && n < DRAIN_LIMIT) begin
      @(posedge clk);
      n++;
    end
    idle_cycles(SLOT_CYCLES);
    @(negedge clk);
    assert ((frames_seen - base_frames) + int'(drop_count) == BURST_EVENTS) else begin
      $display("[FAIL] %0t ns: %0d frames plus %0d drops for %0d burst events",
               $time, frames_seen - base_frames, drop_count, BURST_EVENTS);
      errors++;
    end
    assert (drop_count != '0) else begin
      $display("[FAIL] %0t ns: drop_count is zero after the burst overran the queue",
               $time);
      errors++;
    end
    exp_frames.delete();
    report_test("burst overflow", err_before);

    $display("Summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
    if (tests_failed == 0 && errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    wait (cycle_count >= MAX_CYCLES);
    $display("Timeout, simulation still running after %0d cycles", MAX_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: flist.f
+incdir+test
hw/rope_pkg.sv
hw/pointer_sampler.sv
hw/event_fifo.sv
hw/rope_relax.sv
hw/rope_core.sv
hw/rope_top.sv
test/tb_rope.sv

// File: Bender.yml
package:
  name: rope_sim

sources:
  - files:
      - hw/rope_pkg.sv
      - hw/pointer_sampler.sv
      - hw/event_fifo.sv
      - hw/rope_relax.sv
      - hw/rope_core.sv
      - hw/rope_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_rope.sv
